// File: compile.f
design/mips_pkg.sv
design/main_decoder.sv
design/alu_decoder.sv
design/alu.sv
design/reg_file.sv
design/data_mem.sv
design/exec_core.sv
tests/tb_clock.sv
tests/tb_exec_core.sv

// File: design/alu.sv
module alu import mips_pkg::*; (
  input  logic [DATA_W-1:0] i_a,
  input  logic [DATA_W-1:0] i_b,
  input  alu_op_e           i_op,
  input  logic              i_trap,    // signed overflow check on
  output logic [DATA_W-1:0] o_result,
  output logic              o_overflow
);

  logic [DATA_W-1:0] sum;
  logic [DATA_W-1:0] diff;
  logic              ovf_add;
  logic              ovf_sub;

  assign sum  = i_a + i_b;
  assign diff = i_a - i_b;

  // same-sign operands, result sign flipped
  assign ovf_add = (i_a[DATA_W-1] == i_b[DATA_W-1]) &&
                   (sum[DATA_W-1] != i_a[DATA_W-1]);
  // opposite signs, result takes the sign of b
  assign ovf_sub = (i_a[DATA_W-1] != i_b[DATA_W-1]) &&
                   (diff[DATA_W-1] != i_a[DATA_W-1]);

  always_comb begin
    case (i_op)
      ALU_ADD:  o_result = sum;
      ALU_SUB:  o_result = diff;
      ALU_AND:  o_result = i_a & i_b;
      ALU_OR:   o_result = i_a | i_b;
      ALU_XOR:  o_result = i_a ^ i_b;
      ALU_NOR:  o_result = ~(i_a | i_b);
      ALU_SLT:  o_result = {{(DATA_W-1){1'b0}}, $signed(i_a) < $signed(i_b)};
      ALU_SLTU: o_result = {{(DATA_W-1){1'b0}}, i_a < i_b};
      ALU_LUI:  o_result = i_b << 16; // imm into the upper half
      default:  o_result = sum;
    endcase
  end

  // flag only matters for the trapping add and sub
  always_comb begin
    o_overflow = 1'b0;
    if (i_trap) begin
      if (i_op == ALU_ADD) begin
        o_overflow = ovf_add;
      end else if (i_op == ALU_SUB) begin
        o_overflow = ovf_sub;
      end
    end
  end

endmodule

// File: design/alu_decoder.sv
module alu_decoder import mips_pkg::*; (
  input  alu_class_e i_class,
  input  funct_e     i_funct,
  output alu_op_e    o_op,
  output logic       o_fsigned // r-type add or sub with overflow trap
);

  always_comb begin
    o_op      = ALU_ADD;
    o_fsigned = 1'b0;
    case (i_class)
      CLS_MEM: o_op = ALU_ADD; // effective address
      CLS_ADD: o_op = ALU_ADD;
      CLS_AND: o_op = ALU_AND;
      CLS_OR:  o_op = ALU_OR;
      CLS_XOR: o_op = ALU_XOR;
      CLS_SLT: o_op = ALU_SLT;
      CLS_LUI: o_op = ALU_LUI;
      CLS_RTYPE: begin
        case (i_funct)
          F_ADD: begin
            o_op      = ALU_ADD;
            o_fsigned = 1'b1; // add traps, addu wraps
          end
          F_ADDU: o_op = ALU_ADD;
          F_SUB: begin
            o_op      = ALU_SUB;
            o_fsigned = 1'b1;
          end
          F_SUBU: o_op = ALU_SUB;
          F_AND:  o_op = ALU_AND;
          F_OR:   o_op = ALU_OR;
          F_XOR:  o_op = ALU_XOR;
          F_NOR:  o_op = ALU_NOR;
          F_SLT:  o_op = ALU_SLT;
          F_SLTU: o_op = ALU_SLTU;
          // unsupported funct is undefined, behaves as addu and still writes rd
          default: o_op = ALU_ADD;
        endcase
      end
      default: o_op = ALU_ADD;
    endcase
  end

endmodule

// File: design/data_mem.sv
module data_mem import mips_pkg::*; #(
  parameter int MEM_WORDS = 64 // power of two
) (
  input  logic                         i_clk,
  input  logic                         i_we,
  input  logic [$clog2(MEM_WORDS)-1:0] i_addr, // word index, wraps at depth
  input  logic [DATA_W-1:0]            i_wdata,
  output logic [DATA_W-1:0]            o_rdata
);

  logic [DATA_W-1:0] mem [MEM_WORDS]; // contents undefined after reset

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_addr] <= i_wdata;
    end
  end

  assign o_rdata = mem[i_addr]; // async read

endmodule

// File: design/exec_core.sv
module exec_core import mips_pkg::*; #(
  parameter int MEM_WORDS = 64
) (
  input  logic        i_clk,
  input  logic        i_reset,
  input  logic        i_valid, // one instruction per strobe
  input  logic [31:0] i_instr,
  output wb_t         o_wb
);

  localparam int MEM_AW = $clog2(MEM_WORDS);

  opcode_e           opcode;
  funct_e            funct;
  logic [4:0]        rs;
  logic [4:0]        rt;
  logic [4:0]        rd;
  logic [15:0]       imm;
  ctrl_t             ctrl;
  alu_op_e           alu_op;
  logic              fsigned;
  logic              trap;
  logic [DATA_W-1:0] imm_ext;
  logic [DATA_W-1:0] rs_data;
  logic [DATA_W-1:0] rt_data;
  logic [DATA_W-1:0] opnd_b;
  logic [DATA_W-1:0] alu_result;
  logic              overflow;
  logic [DATA_W-1:0] mem_rdata;
  logic [DATA_W-1:0] wb_data;
  logic [4:0]        dest;
  logic              reg_we;
  logic              mem_we;
  logic              wb_fire;

  // instruction fields
  assign opcode = opcode_e'(i_instr[31:26]);
  assign rs     = i_instr[25:21];
  assign rt     = i_instr[20:16];
  assign rd     = i_instr[15:11];
  assign funct  = funct_e'(i_instr[5:0]);
  assign imm    = i_instr[15:0];

  main_decoder i_main_dec (.i_opcode(opcode), .o_ctrl(ctrl));

  alu_decoder i_alu_dec (
    .i_class   (ctrl.alu_class),
    .i_funct   (funct),
    .o_op      (alu_op),
    .o_fsigned (fsigned)
  );

  reg_file i_regs (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_we      (reg_we),
    .i_waddr   (dest),
    .i_wdata   (wb_data),
    .i_raddr_a (rs),
    .i_raddr_b (rt),
    .o_rdata_a (rs_data),
    .o_rdata_b (rt_data)
  );

  assign imm_ext = ctrl.zext ? {16'b0, imm} : {{16{imm[15]}}, imm};
  assign opnd_b  = ctrl.alusrc ? imm_ext : rt_data;
  // r-type trap comes from funct, i-type from the opcode
  assign trap    = (ctrl.alu_class == CLS_RTYPE) ? fsigned : ctrl.ifsign;

  alu i_alu (
    .i_a        (rs_data),
    .i_b        (opnd_b),
    .i_op       (alu_op),
    .i_trap     (trap),
    .o_result   (alu_result),
    .o_overflow (overflow)
  );

  assign mem_we = i_valid && ctrl.memwrite;

  data_mem #(.MEM_WORDS(MEM_WORDS)) i_dmem (
    .i_clk   (i_clk),
    .i_we    (mem_we),
    .i_addr  (alu_result[MEM_AW+1:2]), // byte address to word index
    .i_wdata (rt_data),
    .o_rdata (mem_rdata)
  );

  assign wb_data = ctrl.memtoreg ? mem_rdata : alu_result;
  assign dest    = ctrl.regdst ? rd : rt;
  assign reg_we  = i_valid && ctrl.regwrite && !overflow; // overflow kills the write
  assign wb_fire = i_valid && (ctrl.regwrite || overflow); // stores and no-ops stay quiet

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_wb <= '0;
    end else begin
      o_wb.valid <= wb_fire; // single-cycle pulse
      if (wb_fire) begin
        o_wb.overflow <= overflow;
        o_wb.addr     <= dest;
        o_wb.data     <= wb_data;
      end
    end
  end

  // every report traces back to a strobe one cycle earlier
  a_wb_after_valid: assert property (@(posedge i_clk) disable iff (i_reset)
    o_wb.valid |-> $past(i_valid));

endmodule

// File: design/main_decoder.sv
module main_decoder import mips_pkg::*; (
  input  opcode_e i_opcode,
  output ctrl_t   o_ctrl
);

  // everything off unless the opcode turns it on
  // unknown opcodes fall through as a no-op
  always_comb begin
    o_ctrl = '0;
    case (i_opcode)
      OP_ADDI: begin
        o_ctrl.regwrite  = 1'b1; // result to rt
        o_ctrl.alusrc    = 1'b1;
        o_ctrl.ifsign    = 1'b1; // overflow drops the write
        o_ctrl.alu_class = CLS_ADD;
      end
      OP_ADDIU: begin
        o_ctrl.regwrite  = 1'b1;
        o_ctrl.alusrc    = 1'b1;
        o_ctrl.alu_class = CLS_ADD; // wraps silently
      end
      OP_RTYPE: begin
        o_ctrl.regdst    = 1'b1; // result to rd
        o_ctrl.regwrite  = 1'b1;
        o_ctrl.alu_class = CLS_RTYPE;
      end

      // logic immediates take the imm zero-extended
      OP_ANDI: begin
        o_ctrl.regwrite  = 1'b1;
        o_ctrl.alusrc    = 1'b1;
        o_ctrl.zext      = 1'b1;
        o_ctrl.alu_class = CLS_AND;
      end
      OP_ORI: begin
        o_ctrl.regwrite  = 1'b1;
        o_ctrl.alusrc    = 1'b1;
        o_ctrl.zext      = 1'b1;
        o_ctrl.alu_class = CLS_OR;
      end
      OP_XORI: begin
        o_ctrl.regwrite  = 1'b1;
        o_ctrl.alusrc    = 1'b1;
        o_ctrl.zext      = 1'b1;
        o_ctrl.alu_class = CLS_XOR;
      end

      OP_LW: begin
        o_ctrl.regwrite  = 1'b1;
        o_ctrl.alusrc    = 1'b1; // base + offset
        o_ctrl.memread   = 1'b1;
        o_ctrl.memtoreg  = 1'b1; // memory word goes back
        o_ctrl.alu_class = CLS_MEM;
      end
      OP_SW: begin
        o_ctrl.alusrc    = 1'b1;
        o_ctrl.memwrite  = 1'b1; // no register write
        o_ctrl.memtoreg  = 1'b1; // don't care, regwrite is low
        o_ctrl.alu_class = CLS_MEM;
      end
      OP_LUI: begin
        // no memory access here, the alu builds the value
        o_ctrl.regwrite  = 1'b1;
        o_ctrl.alusrc    = 1'b1;
        o_ctrl.alu_class = CLS_LUI;
      end
      OP_SLTI: begin
        o_ctrl.regwrite  = 1'b1;
        o_ctrl.alusrc    = 1'b1; // signed imm compare
        o_ctrl.alu_class = CLS_SLT;
      end
      default: begin
        o_ctrl = '0; // no-op
      end
    endcase
  end

  // a single instruction never both reads and writes memory
  a_mem_excl: assert property (@(i_opcode) !(o_ctrl.memread && o_ctrl.memwrite));

endmodule

// File: design/mips_pkg.sv
package mips_pkg;

  localparam int DATA_W = 32; // datapath width, all rtl

  // primary opcode field [31:26], standard mips values
  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000, // funct selects the op
    OP_ADDI  = 6'b001000, // traps on signed overflow
    OP_ADDIU = 6'b001001,
    OP_SLTI  = 6'b001010,
    OP_ANDI  = 6'b001100, // zero-extended imm
    OP_ORI   = 6'b001101, // zero-extended imm
    OP_XORI  = 6'b001110, // zero-extended imm
    OP_LUI   = 6'b001111,
    OP_LW    = 6'b100011, // word load only
    OP_SW    = 6'b101011  // word store only
  } opcode_e;

  // r-type funct field [5:0]
  typedef enum logic [5:0] {
    F_ADD  = 6'b100000,
    F_ADDU = 6'b100001,
    F_SUB  = 6'b100010,
    F_SUBU = 6'b100011,
    F_AND  = 6'b100100,
    F_OR   = 6'b100101,
    F_XOR  = 6'b100110,
    F_NOR  = 6'b100111,
    F_SLT  = 6'b101010,
    F_SLTU = 6'b101011
  } funct_e;

  // alu class out of the main decoder
  typedef enum logic [2:0] {
    CLS_MEM   = 3'd0, // address add for lw and sw
    CLS_RTYPE = 3'd1, // look at funct
    CLS_ADD   = 3'd2,
    CLS_AND   = 3'd3,
    CLS_OR    = 3'd4,
    CLS_XOR   = 3'd5,
    CLS_SLT   = 3'd6,
    CLS_LUI   = 3'd7
  } alu_class_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_NOR, ALU_SLT, ALU_SLTU, ALU_LUI
  } alu_op_e;

  // main control bundle, 11 bits
  typedef struct packed {
    logic       regdst;    // dest is rd, else rt
    logic       regwrite;
    logic       alusrc;    // operand b from immediate
    logic       memread;
    logic       memwrite;
    logic       memtoreg;  // writeback from memory
    logic       ifsign;    // signed overflow traps
    logic       zext;      // zero-extend imm
    alu_class_e alu_class;
  } ctrl_t;

  // writeback observation record, 39 bits
  typedef struct packed {
    logic              valid;
    logic              overflow; // write was dropped
    logic [4:0]        addr;
    logic [DATA_W-1:0] data;
  } wb_t;

endpackage

// File: design/reg_file.sv
module reg_file import mips_pkg::*; (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_we,
  input  logic [4:0]        i_waddr,
  input  logic [DATA_W-1:0] i_wdata,
  input  logic [4:0]        i_raddr_a, // rs
  input  logic [4:0]        i_raddr_b, // rt
  output logic [DATA_W-1:0] o_rdata_a,
  output logic [DATA_W-1:0] o_rdata_b
);

  logic [DATA_W-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != 5'd0)) begin
      regs[i_waddr] <= i_wdata; // r0 stays at zero
    end
  end

  // reads see the write from the previous edge
  assign o_rdata_a = regs[i_raddr_a];
  assign o_rdata_b = regs[i_raddr_b];

  // r0 holds zero whatever was written to it
  a_r0_zero: assert property (@(posedge i_clk) disable iff (i_reset)
    ((i_raddr_a == 5'd0) |-> (o_rdata_a == '0)) and
    ((i_raddr_b == 5'd0) |-> (o_rdata_b == '0)));

endmodule

// File: run.sh
#!/bin/sh
# build and run the exec_core testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f compile.f --top-module tb_exec_core -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

// File: tests/tb_clock.sv
module tb_clock #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 3
) (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // reset high from time zero, dropped on a falling edge
  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset = 1'b0;
  end

endmodule

// File: tests/tb_exec_core.sv
module tb_exec_core import mips_pkg::*; ();

  localparam int MEM_WORDS  = 64;
  localparam int WB_TIMEOUT = 10; // cycles to wait for a writeback

  logic        clk;
  logic        rst;
  logic        valid;
  logic [31:0] instr;
  wb_t         wb;
  logic [31:0] shadow_regs [32]; // reference register file
  logic [31:0] shadow_mem [MEM_WORDS]; // reference data memory

  tb_clock #(.PERIOD(4), .RESET_CYCLES(3)) i_clock (.o_clk(clk), .o_reset(rst));

  exec_core #(.MEM_WORDS(MEM_WORDS)) i_dut (
    .i_clk   (clk),
    .i_reset (rst),
    .i_valid (valid),
    .i_instr (instr),
    .o_wb    (wb)
  );

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_field(input string name, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED %s: %s expected %h actual %h", name, field, exp, act);
      abort_run();
    end
  endtask

  function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
                                        input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // overflow when the top two bits of the sign-extended 33-bit result disagree
  function automatic logic signed_ovf(input logic [31:0] a, input logic [31:0] b,
                                      input logic sub);
    logic [32:0] wide;
    wide = sub ? ({a[31], a} - {b[31], b}) : ({a[31], a} + {b[31], b});
    return wide[32] != wide[31];
  endfunction

  function automatic int mem_index(input logic [31:0] addr);
    return int'((addr >> 2) % MEM_WORDS); // word index of a byte address wraps at depth
  endfunction

  // reference model for one instruction updates the shadow state
  task automatic model_step(input logic [31:0] word, output wb_t exp);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [31:0] zx;
    logic [31:0] res;
    logic [4:0]  dst;
    logic        wr;
    logic        ovf;
    op  = word[31:26];
    fn  = word[5:0];
    a   = shadow_regs[word[25:21]];
    b   = shadow_regs[word[20:16]];
    sx  = {{16{word[15]}}, word[15:0]};
    zx  = {16'h0000, word[15:0]};
    res = a + sx;
    dst = word[20:16]; // rt unless r-type
    wr  = 1'b1;
    ovf = 1'b0;
    case (op)
      OP_RTYPE: begin
        dst = word[15:11];
        case (fn)
          F_ADD:  {res, ovf} = {a + b, signed_ovf(a, b, 1'b0)};
          F_SUB:  {res, ovf} = {a - b, signed_ovf(a, b, 1'b1)};
          F_SUBU: res = a - b;
          F_AND:  res = a & b;
          F_OR:   res = a | b;
          F_XOR:  res = a ^ b;
          F_NOR:  res = ~(a | b);
          F_SLT:  res = {31'd0, $signed(a) < $signed(b)};
          F_SLTU: res = {31'd0, a < b};
          default: res = a + b; // addu
        endcase
      end
      OP_ADDI:  ovf = signed_ovf(a, sx, 1'b0);
      OP_ADDIU: res = a + sx;
      OP_SLTI:  res = {31'd0, $signed(a) < $signed(sx)};
      OP_ANDI:  res = a & zx;
      OP_ORI:   res = a | zx;
      OP_XORI:  res = a ^ zx;
      OP_LUI:   res = {word[15:0], 16'h0000};
      OP_LW:    res = shadow_mem[mem_index(a + sx)];
      OP_SW: begin
        shadow_mem[mem_index(a + sx)] = b;
        wr = 1'b0;
      end
      default: wr = 1'b0; // no-op
    endcase
    exp = '{valid: wr, overflow: ovf, addr: dst, data: res};
    if (wr && !ovf && dst != 5'd0) shadow_regs[dst] = res;
  endtask

  // strobe one instruction on a falling edge and look for its writeback
  task automatic run_instr(input string name, input logic [31:0] word);
    wb_t exp;
    int  waited;
    model_step(word, exp);
    @(negedge clk);
    valid = 1'b1;
    instr = word;
    @(negedge clk); // accepted at the rising edge in between
    valid = 1'b0;
    instr = '0;
    if (exp.valid) begin
      waited = 0;
      while (!wb.valid && waited < WB_TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      if (!wb.valid) begin
        $display("timeout in %s: no writeback within %0d cycles", name, WB_TIMEOUT);
        abort_run();
      end
      check_field(name, "addr", 32'(exp.addr), 32'(wb.addr));
      check_field(name, "data", exp.data, wb.data);
      check_field(name, "overflow", 32'(exp.overflow), 32'(wb.overflow));
    end else begin
      assert (!wb.valid) else begin
        $display("%s: writeback pulse seen where none was expected", name);
        abort_run();
      end
    end
  endtask

  task automatic load_reg(input string name, input logic [4:0] r, input logic [31:0] value);
    run_instr(name, enc_i(OP_LUI, r, 5'd0, value[31:16]));
    run_instr(name, enc_i(OP_ORI, r, r, value[15:0])); // ori zero-extends
  endtask

  task automatic test_reset();
    for (int n = 0; n < 8; n++) begin
      @(negedge clk);
      assert (!wb.valid) else begin
        $display("reset: writeback pulse without any strobe");
        abort_run();
      end
    end
    run_instr("reset", enc_i(OP_ADDI, 5'd1, 5'd0, 16'h0000));
  endtask

  task automatic test_itype();
    load_reg("itype", 5'd2, 32'h1234_5678);
    load_reg("itype", 5'd4, 32'hffff_ff00); // negative for slti
    run_instr("itype addi", enc_i(OP_ADDI, 5'd3, 5'd2, 16'hfffb));
    run_instr("itype addiu", enc_i(OP_ADDIU, 5'd3, 5'd2, 16'h8000));
    run_instr("itype andi", enc_i(OP_ANDI, 5'd3, 5'd4, 16'h8f0f)); // top bit set
    run_instr("itype ori", enc_i(OP_ORI, 5'd3, 5'd2, 16'hf000));
    run_instr("itype xori", enc_i(OP_XORI, 5'd3, 5'd4, 16'h8001));
    run_instr("itype slti", enc_i(OP_SLTI, 5'd3, 5'd4, 16'hff80));
    run_instr("itype slti", enc_i(OP_SLTI, 5'd3, 5'd4, 16'hfe00));
    run_instr("itype lui", enc_i(OP_LUI, 5'd3, 5'd0, 16'habcd));
  endtask

  task automatic test_rtype();
    load_reg("rtype", 5'd5, 32'h7000_1234);
    load_reg("rtype", 5'd6, 32'hf0ff_00ff);
    run_instr("rtype add", enc_r(F_ADD, 5'd9, 5'd5, 5'd6));
    run_instr("rtype addu", enc_r(F_ADDU, 5'd10, 5'd5, 5'd6));
    run_instr("rtype sub", enc_r(F_SUB, 5'd11, 5'd5, 5'd6));
    run_instr("rtype subu", enc_r(F_SUBU, 5'd12, 5'd6, 5'd5));
    run_instr("rtype and", enc_r(F_AND, 5'd13, 5'd5, 5'd6));
    run_instr("rtype or", enc_r(F_OR, 5'd14, 5'd5, 5'd6));
    run_instr("rtype xor", enc_r(F_XOR, 5'd15, 5'd5, 5'd6));
    run_instr("rtype nor", enc_r(F_NOR, 5'd16, 5'd5, 5'd6));
    run_instr("rtype slt", enc_r(F_SLT, 5'd17, 5'd6, 5'd5));
    run_instr("rtype sltu", enc_r(F_SLTU, 5'd18, 5'd6, 5'd5));
    run_instr("rtype r0 write", enc_r(F_ADD, 5'd0, 5'd5, 5'd6)); // pulse without a write
    run_instr("rtype r0 read", enc_r(F_OR, 5'd20, 5'd0, 5'd0));
  endtask

  task automatic test_memory();
    load_reg("memory", 5'd11, 32'h0000_0100);
    load_reg("memory", 5'd12, 32'hdead_beef);
    load_reg("memory", 5'd13, 32'h0bad_f00d);
    run_instr("memory sw", enc_i(OP_SW, 5'd12, 5'd11, 16'h0000)); // no pulse expected
    run_instr("memory sw", enc_i(OP_SW, 5'd13, 5'd11, 16'h0008));
    run_instr("memory sw", enc_i(OP_SW, 5'd12, 5'd11, 16'hfffc));
    run_instr("memory lw", enc_i(OP_LW, 5'd14, 5'd11, 16'h0000));
    run_instr("memory lw", enc_i(OP_LW, 5'd15, 5'd11, 16'h0008));
    run_instr("memory lw", enc_i(OP_LW, 5'd16, 5'd11, 16'hfffc));
    run_instr("memory sw", enc_i(OP_SW, 5'd13, 5'd11, 16'h0000)); // overwrite
    run_instr("memory lw", enc_i(OP_LW, 5'd17, 5'd11, 16'h0000));
  endtask

  task automatic test_overflow();
    load_reg("overflow", 5'd18, 32'h7fff_fff0);
    load_reg("overflow", 5'd19, 32'h0000_0100);
    load_reg("overflow", 5'd20, 32'h8000_0000);
    load_reg("overflow", 5'd21, 32'h0000_1111); // targets hold a known value
    load_reg("overflow", 5'd23, 32'h0000_2222);
    load_reg("overflow", 5'd24, 32'h0000_3333);
    run_instr("overflow addi", enc_i(OP_ADDI, 5'd21, 5'd18, 16'h7fff));
    check_field("overflow addi", "overflow", 32'd1, 32'(wb.overflow));
    run_instr("overflow add", enc_r(F_ADD, 5'd23, 5'd18, 5'd19));
    check_field("overflow add", "overflow", 32'd1, 32'(wb.overflow));
    run_instr("overflow sub", enc_r(F_SUB, 5'd24, 5'd20, 5'd19));
    check_field("overflow sub", "overflow", 32'd1, 32'(wb.overflow));
    run_instr("overflow read", enc_r(F_OR, 5'd22, 5'd21, 5'd0)); // still 0x1111
    run_instr("overflow read", enc_r(F_OR, 5'd22, 5'd23, 5'd0));
    run_instr("overflow read", enc_r(F_OR, 5'd22, 5'd24, 5'd0));
    run_instr("overflow addiu", enc_i(OP_ADDIU, 5'd25, 5'd18, 16'h7fff));
    check_field("overflow addiu", "overflow", 32'd0, 32'(wb.overflow));
    run_instr("overflow addu", enc_r(F_ADDU, 5'd26, 5'd18, 5'd19));
    check_field("overflow addu", "overflow", 32'd0, 32'(wb.overflow));
  endtask

  task automatic test_random();
    logic [31:0] f;
    logic [31:0] word;
    int          sel;
    for (int n = 1; n < 32; n++) begin
      load_reg("random preload", 5'(n), $urandom);
    end
    for (int n = 0; n < 200; n++) begin
      f   = $urandom; // rs [4:0] rt [9:5] rd [14:10] imm [31:16]
      sel = int'($urandom % 17);
      case (sel)
        0:  word = enc_i(OP_ADDI, f[9:5], f[4:0], f[31:16]);
        1:  word = enc_i(OP_ADDIU, f[9:5], f[4:0], f[31:16]);
        2:  word = enc_i(OP_ANDI, f[9:5], f[4:0], f[31:16]);
        3:  word = enc_i(OP_ORI, f[9:5], f[4:0], f[31:16]);
        4:  word = enc_i(OP_XORI, f[9:5], f[4:0], f[31:16]);
        5:  word = enc_i(OP_SLTI, f[9:5], f[4:0], f[31:16]);
        6:  word = enc_i(OP_LUI, f[9:5], f[4:0], f[31:16]);
        7:  word = enc_r(F_ADD, f[14:10], f[4:0], f[9:5]);
        8:  word = enc_r(F_ADDU, f[14:10], f[4:0], f[9:5]);
        9:  word = enc_r(F_SUB, f[14:10], f[4:0], f[9:5]);
        10: word = enc_r(F_SUBU, f[14:10], f[4:0], f[9:5]);
        11: word = enc_r(F_AND, f[14:10], f[4:0], f[9:5]);
        12: word = enc_r(F_OR, f[14:10], f[4:0], f[9:5]);
        13: word = enc_r(F_XOR, f[14:10], f[4:0], f[9:5]);
        14: word = enc_r(F_NOR, f[14:10], f[4:0], f[9:5]);
        15: word = enc_r(F_SLT, f[14:10], f[4:0], f[9:5]);
        default: word = enc_r(F_SLTU, f[14:10], f[4:0], f[9:5]);
      endcase
      run_instr("random", word);
    end
  endtask

  initial begin
    int waited;
    void'($urandom(34));
    valid = 1'b0;
    instr = '0;
    for (int n = 0; n < 32; n++) begin
      shadow_regs[n] = '0; // registers reset to zero
    end
    waited = 0;
    while (rst && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (rst) begin
      $display("reset was never released");
      abort_run();
    end
    test_reset();
    test_itype();
    test_rtype();
    test_memory();
    test_overflow();
    test_random();
    $display("STATUS: PASS");
    $finish;
  end

endmodule
